// File: Makefile
TOOL      = verilator
TOP       = spiMemoryTb
FILELIST  = compile.f
BUILD_DIR = obj_dir
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LOG       = sim.log
FAIL_MSG  = Simulation finished: FAIL

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
+incdir+source
source/spiMemPkg.sv
source/inputConditioner.sv
source/shiftRegister.sv
source/frameSequencer.sv
source/memArray.sv
source/spiMemory.sv
verif/spiMemoryTb.sv

// File: source/frameSequencer.sv
// SPI frame sequencer
`timescale 1ns/1ps

module frameSequencer import spiMemPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       sclkRise,
    input  logic       csActive,
    input  shiftWord_u shiftData,
    output logic       addrLatch,
    output logic       shiftLoad,
    output logic       memWrite,
    output logic       misoEnable
);

    seqState_t state;
    seqState_t nextState;
    logic      readFrame;

    // States follow the bit order, so most steps are a plain increment.
    always_comb begin
        nextState = state;
        if (sclkRise) begin
            case (state)
                rwBit: begin
                    nextState = readFrame ? readBit7 : writeBit7;
                end
                readBit0, writeBit0: begin
                    // Extra clocks after the last bit are ignored until csN rises.
                    nextState = state;
                end
                default: begin
                    nextState = seqState_t'(state + 5'd1);
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state      <= idle;
            readFrame  <= 1'b0;
            addrLatch  <= 1'b0;
            shiftLoad  <= 1'b0;
            memWrite   <= 1'b0;
            misoEnable <= 1'b0;
        end else if (!csActive) begin
            // Deselect ends the frame from any state.
            state      <= idle;
            addrLatch  <= 1'b0;
            shiftLoad  <= 1'b0;
            memWrite   <= 1'b0;
            misoEnable <= 1'b0;
        end else begin
            state <= nextState;

            // Address and direction bit are complete once the 8th bit is in.
            addrLatch <= sclkRise && (state == addrBit0);

            // The direction flag is still in the command view while addrLatch
            // is high; a read load overwrites it one cycle later.
            if (addrLatch) begin
                readFrame <= shiftData.cmd.read;
            end
            shiftLoad <= addrLatch && shiftData.cmd.read;
            if (addrLatch && shiftData.cmd.read) begin
                misoEnable <= 1'b1;
            end

            // Commit a write only after all 16 bits, so an aborted frame leaves memory alone.
            memWrite <= sclkRise && (state == writeBit1);
        end
    end

    // A frame is either a read or a write, so the two strobes exclude each other.
    assert property (@(posedge clk) disable iff (!rstN) !(memWrite && shiftLoad))
        else $error("memWrite and shiftLoad high together");

    assert property (@(posedge clk) disable iff (!rstN)
        memWrite |-> (state inside {[writeBit7:writeBit0]}))
        else $error("memWrite outside the write data states");

endmodule

// File: source/inputConditioner.sv
// SPI input conditioner
`timescale 1ns/1ps

`include "spiMem_defines.svh"

module inputConditioner (
    input  logic clk,
    input  logic rstN,
    input  logic sclk,
    input  logic csN,
    input  logic mosi,
    output logic sclkRise,
    output logic sclkFall,
    output logic csActive,
    output logic mosiSync
);

    logic [`SYNC_STAGES-1:0] sclkChain;
    logic [`SYNC_STAGES-1:0] csChain;
    logic [`SYNC_STAGES-1:0] mosiChain;
    logic                    sclkPrev;

    // The pins are asynchronous to clk, so each one passes a flop chain first.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            sclkChain <= '0;
            csChain   <= '1;
            mosiChain <= '0;
        end else begin
            sclkChain <= {sclkChain[`SYNC_STAGES-2:0], sclk};
            csChain   <= {csChain[`SYNC_STAGES-2:0], csN};
            mosiChain <= {mosiChain[`SYNC_STAGES-2:0], mosi};
        end
    end

    // Edge pulses are registered, and the chip select and data outputs get
    // one more flop as well so all four stay aligned.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            sclkPrev <= 1'b0;
            sclkRise <= 1'b0;
            sclkFall <= 1'b0;
            csActive <= 1'b0;
            mosiSync <= 1'b0;
        end else begin
            sclkPrev <= sclkChain[`SYNC_STAGES-1];
            sclkRise <= sclkChain[`SYNC_STAGES-1] & ~sclkPrev;
            sclkFall <= ~sclkChain[`SYNC_STAGES-1] & sclkPrev;
            csActive <= ~csChain[`SYNC_STAGES-1];
            mosiSync <= mosiChain[`SYNC_STAGES-1];
        end
    end

    // A pulse needs a level change between two samples, so both at once means
    // the edge detector is broken.
    assert property (@(posedge clk) disable iff (!rstN) !(sclkRise && sclkFall))
        else $error("sclkRise and sclkFall high together");

endmodule

// File: source/memArray.sv
// SPI memory array
`timescale 1ns/1ps

`include "spiMem_defines.svh"

module memArray import spiMemPkg::*; (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       addrLatch,
    input  logic                       memWrite,
    input  shiftWord_u                 shiftData,
    output logic [`SPI_DATA_WIDTH-1:0] readData
);

    logic [`SPI_DATA_WIDTH-1:0] mem [`MEM_DEPTH];
    logic [`SPI_ADDR_WIDTH-1:0] addrReg;
    logic [`SPI_ADDR_WIDTH-1:0] readAddr;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            addrReg <= '0;
        end else if (addrLatch) begin
            addrReg <= shiftData.cmd.addr;
        end
    end

    // The incoming address is forwarded while it is being latched.
    // That way the byte is ready for the sequencer's load one cycle later.
    assign readAddr = addrLatch ? shiftData.cmd.addr : addrReg;

    always_ff @(posedge clk) begin
        readData <= mem[readAddr];
    end

    always_ff @(posedge clk) begin
        if (memWrite) begin
            mem[addrReg] <= shiftData.data;
        end
    end

    // The latch fires early in the frame and the write at its end.
    // Overlap would write to an address still being changed.
    assert property (@(posedge clk) disable iff (!rstN) !(addrLatch && memWrite))
        else $error("addrLatch and memWrite high together");

endmodule

// File: source/shiftRegister.sv
// SPI frame shift register
`timescale 1ns/1ps

`include "spiMem_defines.svh"

module shiftRegister import spiMemPkg::*; (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       sclkRise,
    input  logic                       sclkFall,
    input  logic                       mosiSync,
    input  logic                       shiftLoad,
    input  logic [`SPI_DATA_WIDTH-1:0] readData,
    output shiftWord_u                 shiftData,
    output logic                       misoBit
);

    // A load from memory comes between the 8th and 9th rising edges, so it
    // never competes with a shift in a well formed frame.
    always_ff @(posedge clk) begin
        if (shiftLoad) begin
            shiftData.data <= readData;
        end else if (sclkRise) begin
            shiftData.data <= {shiftData.data[`SPI_DATA_WIDTH-2:0], mosiSync};
        end
    end

    // The output bit changes only on falling edges.
    // It is stable around the rising edge where the master samples it.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            misoBit <= 1'b0;
        end else if (sclkFall) begin
            misoBit <= shiftData.data[`SPI_DATA_WIDTH-1];
        end
    end

endmodule

// File: source/spiMemPkg.sv
// SPI memory types

`include "spiMem_defines.svh"

package spiMemPkg;

    // One state per frame bit, in the order the bits arrive.
    typedef enum logic [4:0] {
        idle,
        addrBit6, addrBit5, addrBit4, addrBit3, addrBit2, addrBit1, addrBit0,
        rwBit,
        readBit7, readBit6, readBit5, readBit4, readBit3, readBit2, readBit1, readBit0,
        writeBit7, writeBit6, writeBit5, writeBit4, writeBit3, writeBit2, writeBit1,
        writeBit0
    } seqState_t;

    // Command view: the address sits above the direction flag.
    typedef struct packed {
        logic [`SPI_ADDR_WIDTH-1:0] addr;
        logic                       read;
    } spiCmd_t;

    // The shift register byte is a command early in the frame and data later on.
    typedef union packed {
        spiCmd_t                    cmd;
        logic [`SPI_DATA_WIDTH-1:0] data;
    } shiftWord_u;

endpackage

// File: source/spiMem_defines.svh
// SPI memory sizes

`ifndef SPIMEM_DEFINES_SVH
`define SPIMEM_DEFINES_SVH

// Address bits sent at the start of every frame.
`define SPI_ADDR_WIDTH 7

// Data bits per frame, also the width of one memory word.
`define SPI_DATA_WIDTH 8

// Number of memory words, one per address.
`define MEM_DEPTH 128

// Flip-flops in each input synchronizer chain.
`define SYNC_STAGES 2

`endif

// File: source/spiMemory.sv
// SPI memory top level
`timescale 1ns/1ps

`include "spiMem_defines.svh"

module spiMemory import spiMemPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic sclk,
    input  logic csN,
    input  logic mosi,
    output logic miso,
    output logic misoEnable
);

    logic                       sclkRise;
    logic                       sclkFall;
    logic                       csActive;
    logic                       mosiSync;
    logic                       addrLatch;
    logic                       shiftLoad;
    logic                       memWrite;
    shiftWord_u                 shiftData;
    logic [`SPI_DATA_WIDTH-1:0] readData;

    inputConditioner inputConditioner_i (
        .clk      (clk),
        .rstN     (rstN),
        .sclk     (sclk),
        .csN      (csN),
        .mosi     (mosi),
        .sclkRise (sclkRise),
        .sclkFall (sclkFall),
        .csActive (csActive),
        .mosiSync (mosiSync)
    );

    shiftRegister shiftRegister_i (
        .clk       (clk),
        .rstN      (rstN),
        .sclkRise  (sclkRise),
        .sclkFall  (sclkFall),
        .mosiSync  (mosiSync),
        .shiftLoad (shiftLoad),
        .readData  (readData),
        .shiftData (shiftData),
        .misoBit   (miso)
    );

    frameSequencer frameSequencer_i (
        .clk        (clk),
        .rstN       (rstN),
        .sclkRise   (sclkRise),
        .csActive   (csActive),
        .shiftData  (shiftData),
        .addrLatch  (addrLatch),
        .shiftLoad  (shiftLoad),
        .memWrite   (memWrite),
        .misoEnable (misoEnable)
    );

    memArray memArray_i (
        .clk       (clk),
        .rstN      (rstN),
        .addrLatch (addrLatch),
        .memWrite  (memWrite),
        .shiftData (shiftData),
        .readData  (readData)
    );

endmodule

// File: verif/spiMemoryTb.sv
// SPI memory testbench
`timescale 1ns/1ps

`include "spiMem_defines.svh"

module spiMemoryTb;

    // Clock cycles per sclk level. The DUT needs at least 6.
    localparam int HALF_BIT = 8;
    localparam int FRAME_BITS = `SPI_ADDR_WIDTH + 1 + `SPI_DATA_WIDTH;
    // Lead in, all frame bits, lead out and the idle gap after csN rises.
    localparam int FRAME_CYCLES = HALF_BIT * (2 * FRAME_BITS + 4);
    // The tests send about 75 frames, so 85 leaves some headroom.
    localparam int MAX_FRAMES = 85;
    localparam int TIMEOUT_CYCLES = MAX_FRAMES * FRAME_CYCLES + 200;

    logic clk;
    logic rstN;
    logic sclk;
    logic csN;
    logic mosi;
    logic miso;
    logic misoEnable;

    // Reference model of the memory, with a flag for every written address.
    logic [`SPI_DATA_WIDTH-1:0] refMem [`MEM_DEPTH];
    logic                       refValid [`MEM_DEPTH];

    integer seed;
    int     errorCount = 0;
    int     monitorErrors = 0;
    int     checkCount = 0;
    int     cycleCount = 0;
    logic   enableMustBeLow = 1'b0;

    spiMemory spiMemory_i (
        .clk        (clk),
        .rstN       (rstN),
        .sclk       (sclk),
        .csN        (csN),
        .mosi       (mosi),
        .miso       (miso),
        .misoEnable (misoEnable)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES) begin
            $display("Timeout: run exceeded %0d clock cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Outside read frames the output enable must stay low on every cycle.
    always @(negedge clk) begin
        if (enableMustBeLow && misoEnable !== 1'b0) begin
            monitorErrors++;
            $display("CHECK FAILED at %0t: misoEnable = %b, expected 0", $time, misoEnable);
        end
    end

    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // One bit: mosi is set while sclk is low and miso is sampled just before the rise.
    task automatic shiftBit(input logic txBit, output logic rxBit);
        mosi = txBit;
        waitCycles(HALF_BIT);
        rxBit = miso;
        sclk = 1'b1;
        waitCycles(HALF_BIT);
        sclk = 1'b0;
    endtask

    task automatic startFrame();
        sclk = 1'b0;
        csN  = 1'b0;
        waitCycles(HALF_BIT);
    endtask

    task automatic endFrame();
        waitCycles(HALF_BIT);
        csN  = 1'b1;
        mosi = 1'b0;
        waitCycles(2 * HALF_BIT);
    endtask

    task automatic sendCommand(input logic [`SPI_ADDR_WIDTH-1:0] addr, input logic isRead);
        logic [`SPI_DATA_WIDTH-1:0] cmd;
        logic                       unused;
        cmd = {addr, isRead};
        repeat (`SPI_ADDR_WIDTH + 1) begin
            shiftBit(cmd[`SPI_DATA_WIDTH-1], unused);
            cmd = cmd << 1;
        end
    endtask

    task automatic writeFrame(input logic [`SPI_ADDR_WIDTH-1:0] addr,
                              input logic [`SPI_DATA_WIDTH-1:0] data);
        logic [`SPI_DATA_WIDTH-1:0] txByte;
        logic                       unused;
        txByte = data;
        startFrame();
        sendCommand(addr, 1'b0);
        repeat (`SPI_DATA_WIDTH) begin
            shiftBit(txByte[`SPI_DATA_WIDTH-1], unused);
            txByte = txByte << 1;
        end
        endFrame();
        refMem[addr]   = data;
        refValid[addr] = 1'b1;
    endtask

    task automatic readFrame(input logic [`SPI_ADDR_WIDTH-1:0] addr,
                             output logic [`SPI_DATA_WIDTH-1:0] data);
        logic rxBit;
        enableMustBeLow = 1'b0;
        startFrame();
        sendCommand(addr, 1'b1);
        data = '0;
        repeat (`SPI_DATA_WIDTH) begin
            checkCount++;
            if (misoEnable !== 1'b1) begin
                errorCount++;
                $display("CHECK FAILED at %0t: misoEnable = %b, expected 1",
                         $time, misoEnable);
            end
            shiftBit(1'b0, rxBit);
            data = {data[`SPI_DATA_WIDTH-2:0], rxBit};
        end
        endFrame();
        checkCount++;
        if (misoEnable !== 1'b0) begin
            errorCount++;
            $display("CHECK FAILED at %0t: misoEnable = %b, expected 0", $time, misoEnable);
        end
        enableMustBeLow = 1'b1;
    endtask

    // Write frame cut short by csN. The data sent is the inverse of the stored byte.
    task automatic abortFrame(input logic [`SPI_ADDR_WIDTH-1:0] addr, input int bitsSent);
        logic [`SPI_DATA_WIDTH-1:0] txByte;
        logic                       unused;
        txByte = ~refMem[addr];
        startFrame();
        sendCommand(addr, 1'b0);
        repeat (bitsSent - (`SPI_ADDR_WIDTH + 1)) begin
            shiftBit(txByte[`SPI_DATA_WIDTH-1], unused);
            txByte = txByte << 1;
        end
        endFrame();
    endtask

    task automatic checkRead(input logic [`SPI_ADDR_WIDTH-1:0] addr);
        logic [`SPI_DATA_WIDTH-1:0] got;
        readFrame(addr, got);
        checkCount++;
        if (got !== refMem[addr]) begin
            errorCount++;
            $display("CHECK FAILED at %0t: miso byte at address 0x%h = 0x%h, expected 0x%h",
                     $time, addr, got, refMem[addr]);
        end
    endtask

    task automatic testResetIdle();
        checkCount++;
        if (misoEnable !== 1'b0) begin
            errorCount++;
            $display("CHECK FAILED at %0t: misoEnable = %b, expected 0", $time, misoEnable);
        end
        enableMustBeLow = 1'b1;
        waitCycles(4 * HALF_BIT);
        writeFrame(7'($random(seed)), 8'($random(seed)));
    endtask

    task automatic testWriteReadBack();
        logic [`SPI_ADDR_WIDTH-1:0] addr;
        addr = 7'($random(seed));
        writeFrame(addr, 8'($random(seed)));
        checkRead(addr);
    endtask

    // Later writes to the same address replace earlier ones in the model too.
    task automatic testRandomTraffic();
        logic [`SPI_ADDR_WIDTH-1:0] addr;
        repeat (32) begin
            writeFrame(7'($random(seed)), 8'($random(seed)));
        end
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            addr = 7'(i);
            if (refValid[addr]) begin
                checkRead(addr);
            end
        end
    endtask

    task automatic testAbortedWrite();
        logic [`SPI_ADDR_WIDTH-1:0] addr;
        addr = 7'($random(seed));
        writeFrame(addr, 8'($random(seed)));
        abortFrame(addr, 12);
        checkRead(addr);
    endtask

    task automatic testMisoEnable();
        logic [`SPI_ADDR_WIDTH-1:0] addr;
        addr = 7'($random(seed));
        writeFrame(addr, 8'($random(seed)));
        checkRead(addr);
    endtask

    initial begin
        int totalErrors;
        seed = 27;
        rstN = 1'b0;
        sclk = 1'b0;
        csN  = 1'b1;
        mosi = 1'b0;
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            refValid[7'(i)] = 1'b0;
        end
        repeat (5) @(posedge clk);
        #2;
        rstN = 1'b1;

        testResetIdle();
        testWriteReadBack();
        testRandomTraffic();
        testAbortedWrite();
        testMisoEnable();

        totalErrors = errorCount + monitorErrors;
        $display("Checks: %0d, errors: %0d", checkCount, totalErrors);
        if (totalErrors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
